//--- filelist.f
rtl/rs_pkg.sv
rtl/rs_dispatch.sv
rtl/rs_station.sv
rtl/rs_release.sv
rtl/rs_top.sv
bench/rs_properties.sv
bench/rs_tb.sv

//--- Makefile
TOP := rs_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f --Mdir obj_dir -o sim
	-./obj_dir/sim +verilator+error+limit+100 > sim.log 2>&1
	@cat sim.log
	@grep -qx "TB PASSED" sim.log || (echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- bench/rs_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rs_tb;

    localparam int NUM_RS       = rs_pkg::NUM_RS;
    localparam int ROB_ID_W     = rs_pkg::ROB_ID_W;
    localparam int NUM_ROB      = 2**ROB_ID_W;
    localparam int LANES        = rs_pkg::DISPATCH_W;
    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_CYCLES   = 2000;
    // test length plus reset, with a 20 % margin
    localparam int WATCHDOG_NS  = (NUM_CYCLES + RESET_CYCLES) * PERIOD * 12 / 10;

    logic                            clk;
    logic                            arst_n;
    logic                            flush;
    logic              [LANES-1:0]      inst_valid;
    rs_pkg::opcode_t   [LANES-1:0]      opcode;
    logic              [LANES-1:0][2:0] funct3;
    logic              [LANES-1:0][6:0] funct7;
    rs_pkg::word_t     [LANES-1:0]      pc;
    rs_pkg::word_t     [LANES-1:0]      imm_i;
    rs_pkg::word_t     [LANES-1:0]      imm_u;
    rs_pkg::word_t     [LANES-1:0]      imm_j;
    logic              [LANES-1:0]      src1_ready;
    logic              [LANES-1:0]      src2_ready;
    rs_pkg::word_t     [LANES-1:0]      src1_data;
    rs_pkg::word_t     [LANES-1:0]      src2_data;
    rs_pkg::rob_id_t   [LANES-1:0]      src1_rob;
    rs_pkg::rob_id_t   [LANES-1:0]      src2_rob;
    rs_pkg::rob_id_t   [LANES-1:0]      rob_dest;
    logic              [NUM_ROB-1:0]    rob_ready;
    rs_pkg::word_t     [NUM_ROB-1:0]    rob_data;
    logic              [NUM_RS-1:0]     ex_done;
    rs_pkg::rob_id_t   [NUM_RS-1:0]     ex_rob_id;
    rs_pkg::word_t     [NUM_RS-1:0]     ex_data;
    logic                               full;
    rs_pkg::rs_entry_t [NUM_RS-1:0]     station_entry;
    rs_pkg::word_t     [NUM_RS-1:0]     trace_rs1_v;
    rs_pkg::word_t     [NUM_RS-1:0]     trace_rs2_v;

    // expected contents of every station
    rs_pkg::rs_entry_t model [NUM_RS];
    int                prop_fails [NUM_RS];
    int                errors = 0;
    int                checks = 0;

    rs_top #(
        .NUM_RS   (NUM_RS),
        .ROB_ID_W (ROB_ID_W)
    ) DUT (.*);

    // failure counts of the bound station assertions
    for (genvar g = 0; g < NUM_RS; g++) begin : g_prop
        assign prop_fails[g] = DUT.g_station[g].u_station.u_props.fail_count;
    end

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic int busy_count();
        int n;
        n = 0;
        for (int i = 0; i < NUM_RS; i++) begin
            n += int'(model[i].valid);
        end
        return n;
    endfunction

    function automatic rs_pkg::opcode_t random_opcode();
        case ($urandom_range(6))
            0: return rs_pkg::OP_LUI;
            1: return rs_pkg::OP_AUIPC;
            2: return rs_pkg::OP_IMM;
            3: return rs_pkg::OP_REG;
            4: return rs_pkg::OP_JAL;
            5: return rs_pkg::OP_JALR;
            default: return rs_pkg::OP_BR;
        endcase
    endfunction

    // entry that a lane's instruction should leave in its station
    function automatic rs_pkg::rs_entry_t expected_entry(int l);
        rs_pkg::rs_entry_t e;
        e          = '0;
        e.valid    = 1'b1;
        e.opcode   = opcode[l];
        e.funct3   = funct3[l];
        e.funct7   = funct7[l];
        e.rob_id1  = src1_rob[l];
        e.rob_id2  = src2_rob[l];
        e.rob_dest = rob_dest[l];
        e.alu_op   = rs_pkg::ALU_ADD;
        e.cmp_op   = rs_pkg::CMP_BEQ;
        // register file value, else the rob entry behind the tag
        if (src1_ready[l]) begin
            e.r1    = 1'b1;
            e.rs1_v = src1_data[l];
        end else begin
            e.r1    = rob_ready[src1_rob[l]];
            e.rs1_v = rob_data[src1_rob[l]];
        end
        if (src2_ready[l]) begin
            e.r2    = 1'b1;
            e.rs2_v = src2_data[l];
        end else begin
            e.r2    = rob_ready[src2_rob[l]];
            e.rs2_v = rob_data[src2_rob[l]];
        end
        case (opcode[l])
            rs_pkg::OP_LUI: begin
                e.rs1_v = imm_u[l];
                e.rs2_v = '0;
                e.r1    = 1'b1;
                e.r2    = 1'b1;
            end
            rs_pkg::OP_AUIPC: begin
                e.rs1_v = pc[l];
                e.rs2_v = imm_u[l];
                e.r1    = 1'b1;
                e.r2    = 1'b1;
            end
            rs_pkg::OP_JAL: begin
                e.rs1_v = pc[l];
                e.rs2_v = imm_j[l];
                e.r1    = 1'b1;
                e.r2    = 1'b1;
            end
            rs_pkg::OP_JALR, rs_pkg::OP_IMM: begin
                e.rs2_v = imm_i[l];
                e.r2    = 1'b1;
            end
            default: begin
            end
        endcase
        if (opcode[l] == rs_pkg::OP_BR) begin
            e.use_cmp = 1'b1;
            e.cmp_op  = rs_pkg::cmp_op_t'(funct3[l]);
        end else if (opcode[l] == rs_pkg::OP_IMM || opcode[l] == rs_pkg::OP_REG) begin
            if (funct3[l] == 3'b010 || funct3[l] == 3'b011) begin
                e.use_cmp = 1'b1;
                e.cmp_op  = funct3[l][0] ? rs_pkg::CMP_BLTU : rs_pkg::CMP_BLT;
            end else if (funct3[l] == 3'b101) begin
                e.alu_op = funct7[l][5] ? rs_pkg::ALU_SRA : rs_pkg::ALU_SRL;
            end else if (funct3[l] == 3'b000 && opcode[l] == rs_pkg::OP_REG && funct7[l][5]) begin
                e.alu_op = rs_pkg::ALU_SUB;
            end else begin
                e.alu_op = rs_pkg::alu_op_t'(funct3[l]);
            end
        end
        return e;
    endfunction

    task automatic check_entry(input string name, input rs_pkg::rs_entry_t exp,
                               input rs_pkg::rs_entry_t act);
        logic ok;
        ok = exp.valid == act.valid && exp.r1 == act.r1 && exp.r2 == act.r2;
        // payload matters in a live entry, operand values once ready
        if (exp.valid) begin
            ok = ok && exp.opcode == act.opcode && exp.funct3 == act.funct3
                    && exp.funct7 == act.funct7 && exp.use_cmp == act.use_cmp
                    && exp.rob_id1 == act.rob_id1 && exp.rob_id2 == act.rob_id2
                    && exp.rob_dest == act.rob_dest;
            if (exp.use_cmp) begin
                ok = ok && exp.cmp_op == act.cmp_op;
            end else begin
                ok = ok && exp.alu_op == act.alu_op;
            end
            if (exp.r1) begin
                ok = ok && exp.rs1_v == act.rs1_v;
            end
            if (exp.r2) begin
                ok = ok && exp.rs2_v == act.rs2_v;
            end
        end
        checks++;
        if (ok !== 1'b1) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input rs_pkg::word_t exp,
                              input rs_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic init_inputs();
        flush      = 1'b0;
        inst_valid = '0;
        for (int l = 0; l < LANES; l++) begin
            opcode[l] = rs_pkg::OP_LUI;
        end
        funct3     = '0;
        funct7     = '0;
        pc         = '0;
        imm_i      = '0;
        imm_u      = '0;
        imm_j      = '0;
        src1_ready = '0;
        src2_ready = '0;
        src1_data  = '0;
        src2_data  = '0;
        src1_rob   = '0;
        src2_rob   = '0;
        rob_dest   = '0;
        rob_ready  = '0;
        rob_data   = '0;
        ex_done    = '0;
        ex_rob_id  = '0;
        ex_data    = '0;
    endtask

    task automatic drive_cycle();
        int busy;
        busy  = busy_count();
        // a mispredict also lets dispatch run into a near-full array
        flush = ($urandom_range(59) == 0);
        for (int r = 0; r < NUM_ROB; r++) begin
            rob_ready[r] = ($urandom_range(3) == 0);
            rob_data[r]  = $urandom();
        end
        inst_valid = '0;
        if (flush || busy < NUM_RS - 3) begin
            inst_valid = LANES'($urandom_range(3));
        end
        for (int l = 0; l < LANES; l++) begin
            opcode[l]     = random_opcode();
            funct3[l]     = 3'($urandom_range(7));
            funct7[l]     = 7'($urandom());
            pc[l]         = $urandom();
            imm_i[l]      = $urandom();
            imm_u[l]      = $urandom() & 32'hffff_f000;
            imm_j[l]      = $urandom();
            src1_ready[l] = ($urandom_range(1) == 1);
            src2_ready[l] = ($urandom_range(1) == 1);
            src1_data[l]  = $urandom();
            src2_data[l]  = $urandom();
            src1_rob[l]   = rs_pkg::rob_id_t'($urandom());
            src2_rob[l]   = rs_pkg::rob_id_t'($urandom());
            rob_dest[l]   = rs_pkg::rob_id_t'($urandom());
        end
        // only entries with both operands ready issue
        for (int i = 0; i < NUM_RS; i++) begin
            ex_done[i]   = model[i].valid && model[i].r1 && model[i].r2
                           && ($urandom_range(7) == 0);
            ex_rob_id[i] = rs_pkg::rob_id_t'($urandom());
            ex_data[i]   = $urandom();
        end
    endtask

    // compare before the edge takes effect, then step the model over it
    always @(posedge clk) begin : compare
        int busy;
        int lo;
        int hi;
        if (arst_n) begin
            busy = busy_count();
            for (int i = 0; i < NUM_RS; i++) begin
                check_entry($sformatf("station %0d", i), model[i], station_entry[i]);
                check_word($sformatf("trace rs1 %0d", i),
                           ex_done[i] ? model[i].rs1_v : '0, trace_rs1_v[i]);
                check_word($sformatf("trace rs2 %0d", i),
                           (ex_done[i] && model[i].opcode != rs_pkg::OP_IMM) ?
                           model[i].rs2_v : '0, trace_rs2_v[i]);
            end
            check_bit("full", busy >= NUM_RS - 1 || (busy >= NUM_RS - 3 && inst_valid != '0),
                      full);
            lo = -1;
            hi = -1;
            for (int i = 0; i < NUM_RS; i++) begin
                if (!model[i].valid) begin
                    if (lo < 0) begin
                        lo = i;
                    end
                    hi = i;
                end
            end
            for (int i = 0; i < NUM_RS; i++) begin
                if (model[i].valid && !model[i].r1 && rob_ready[model[i].rob_id1]) begin
                    model[i].r1    = 1'b1;
                    model[i].rs1_v = rob_data[model[i].rob_id1];
                end
                if (model[i].valid && !model[i].r2 && rob_ready[model[i].rob_id2]) begin
                    model[i].r2    = 1'b1;
                    model[i].rs2_v = rob_data[model[i].rob_id2];
                end
                if (ex_done[i] || flush) begin
                    model[i].valid = 1'b0;
                    model[i].r1    = 1'b0;
                    model[i].r2    = 1'b0;
                end
            end
            // lane 0 goes last so it keeps a slot both lanes point at
            if (!flush && inst_valid[1] && hi >= 0) begin
                model[hi] = expected_entry(1);
            end
            if (!flush && inst_valid[0] && lo >= 0) begin
                model[lo] = expected_entry(0);
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired before the test sequence finished");
        $display("TB FAILED");
        $finish;
    end

    initial begin : stimulus
        int assert_fails;
        void'($urandom(13393));
        for (int i = 0; i < NUM_RS; i++) begin
            model[i] = '0;
        end
        init_inputs();
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        repeat (NUM_CYCLES) begin
            @(negedge clk);
            drive_cycle();
        end
        @(negedge clk);
        assert_fails = 0;
        for (int i = 0; i < NUM_RS; i++) begin
            assert_fails += prop_fails[i];
        end
        $display("%0d checks, %0d check errors, %0d assertion failures",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/rs_properties.sv
`timescale 1ns/100ps
`default_nettype none

module rs_station_properties (
    input logic              clk,
    input logic              arst_n,
    input logic              flush,
    input logic              load,
    input rs_pkg::rs_entry_t entry
);

    int fail_count = 0;

    // mispredict empties the entry at the next edge
    flush_clears: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !entry.valid)
    else begin
        fail_count++;
        $error("station still valid one cycle after flush");
    end

    // a ready first operand stays ready while the entry lives on unreloaded
    r1_holds: assert property (@(posedge clk) disable iff (!arst_n)
        (entry.valid && entry.r1 && !load) |=> (!entry.valid || entry.r1))
    else begin
        fail_count++;
        $error("first operand ready flag dropped in a live entry");
    end

    load_sets_valid: assert property (@(posedge clk) disable iff (!arst_n)
        (load && !flush) |=> entry.valid)
    else begin
        fail_count++;
        $error("station not valid after a load");
    end

endmodule

bind rs_station rs_station_properties u_props (
    .clk    (clk),
    .arst_n (arst_n),
    .flush  (flush),
    .load   (load),
    .entry  (entry)
);

`default_nettype wire

//--- rtl/rs_top.sv
`timescale 1ns/100ps
`default_nettype none

module rs_top #(
    parameter int NUM_RS   = rs_pkg::NUM_RS,
    parameter int ROB_ID_W = rs_pkg::ROB_ID_W
) (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  logic                                       flush,
    input  logic              [rs_pkg::DISPATCH_W-1:0] inst_valid,
    input  rs_pkg::opcode_t   [rs_pkg::DISPATCH_W-1:0] opcode,
    input  logic [rs_pkg::DISPATCH_W-1:0][2:0]         funct3,
    input  logic [rs_pkg::DISPATCH_W-1:0][6:0]         funct7,
    input  rs_pkg::word_t     [rs_pkg::DISPATCH_W-1:0] pc,
    input  rs_pkg::word_t     [rs_pkg::DISPATCH_W-1:0] imm_i,
    input  rs_pkg::word_t     [rs_pkg::DISPATCH_W-1:0] imm_u,
    input  rs_pkg::word_t     [rs_pkg::DISPATCH_W-1:0] imm_j,
    input  logic              [rs_pkg::DISPATCH_W-1:0] src1_ready,
    input  logic              [rs_pkg::DISPATCH_W-1:0] src2_ready,
    input  rs_pkg::word_t     [rs_pkg::DISPATCH_W-1:0] src1_data,
    input  rs_pkg::word_t     [rs_pkg::DISPATCH_W-1:0] src2_data,
    input  rs_pkg::rob_id_t   [rs_pkg::DISPATCH_W-1:0] src1_rob,
    input  rs_pkg::rob_id_t   [rs_pkg::DISPATCH_W-1:0] src2_rob,
    input  rs_pkg::rob_id_t   [rs_pkg::DISPATCH_W-1:0] rob_dest,
    input  logic              [2**ROB_ID_W-1:0]        rob_ready,
    input  rs_pkg::word_t     [2**ROB_ID_W-1:0]        rob_data,
    input  logic              [NUM_RS-1:0]             ex_done,
    input  rs_pkg::rob_id_t   [NUM_RS-1:0]             ex_rob_id,
    input  rs_pkg::word_t     [NUM_RS-1:0]             ex_data,
    output logic                                       full,
    output rs_pkg::rs_entry_t [NUM_RS-1:0]             station_entry,
    output rs_pkg::word_t     [NUM_RS-1:0]             trace_rs1_v,
    output rs_pkg::word_t     [NUM_RS-1:0]             trace_rs2_v
);

    logic              [NUM_RS-1:0] load;
    rs_pkg::rs_entry_t [NUM_RS-1:0] load_entry;

    rs_dispatch #(
        .NUM_RS   (NUM_RS),
        .ROB_ID_W (ROB_ID_W)
    ) u_dispatch (
        .station_entry (station_entry),
        .inst_valid    (inst_valid),
        .opcode        (opcode),
        .funct3        (funct3),
        .funct7        (funct7),
        .pc            (pc),
        .imm_i         (imm_i),
        .imm_u         (imm_u),
        .imm_j         (imm_j),
        .src1_ready    (src1_ready),
        .src2_ready    (src2_ready),
        .src1_data     (src1_data),
        .src2_data     (src2_data),
        .src1_rob      (src1_rob),
        .src2_rob      (src2_rob),
        .rob_dest      (rob_dest),
        .rob_ready     (rob_ready),
        .rob_data      (rob_data),
        .load          (load),
        .load_entry    (load_entry)
    );

    // one station per execution unit
    for (genvar i = 0; i < NUM_RS; i++) begin : g_station
        rs_station #(
            .ROB_ID_W (ROB_ID_W)
        ) u_station (
            .clk        (clk),
            .arst_n     (arst_n),
            .flush      (flush),
            .load       (load[i]),
            .load_entry (load_entry[i]),
            .rob_ready  (rob_ready),
            .rob_data   (rob_data),
            .ex_done    (ex_done[i]),
            .ex_rob_id  (ex_rob_id[i]),
            .ex_data    (ex_data[i]),
            .entry      (station_entry[i])
        );
    end

    rs_release #(
        .NUM_RS (NUM_RS)
    ) u_release (
        .station_entry (station_entry),
        .inst_valid    (inst_valid),
        .ex_done       (ex_done),
        .full          (full),
        .trace_rs1_v   (trace_rs1_v),
        .trace_rs2_v   (trace_rs2_v)
    );

endmodule

`default_nettype wire

//--- rtl/rs_release.sv
`timescale 1ns/100ps
`default_nettype none

module rs_release #(
    parameter int NUM_RS = rs_pkg::NUM_RS
) (
    input  rs_pkg::rs_entry_t [NUM_RS-1:0]             station_entry,
    input  logic              [rs_pkg::DISPATCH_W-1:0] inst_valid,
    input  logic              [NUM_RS-1:0]             ex_done,
    output logic                                       full,
    output rs_pkg::word_t     [NUM_RS-1:0]             trace_rs1_v,
    output rs_pkg::word_t     [NUM_RS-1:0]             trace_rs2_v
);

    localparam int CNT_W = $clog2(NUM_RS + 1);

    logic [CNT_W-1:0] busy_cnt;

    always_comb begin
        busy_cnt = '0;
        for (int i = 0; i < NUM_RS; i++) begin
            busy_cnt = busy_cnt + CNT_W'(station_entry[i].valid);
        end
    end

    // look-ahead leaves room for a dual dispatch in flight
    assign full = (busy_cnt >= CNT_W'(NUM_RS - 1)) ||
                  ((busy_cnt >= CNT_W'(NUM_RS - 3)) && |inst_valid);

    always_comb begin
        for (int k = 0; k < NUM_RS; k++) begin
            trace_rs1_v[k] = '0;
            trace_rs2_v[k] = '0;
            if (ex_done[k]) begin
                trace_rs1_v[k] = station_entry[k].rs1_v;
                // op-imm second operand is an immediate, not a register
                if (station_entry[k].opcode != rs_pkg::OP_IMM) begin
                    trace_rs2_v[k] = station_entry[k].rs2_v;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/rs_station.sv
`timescale 1ns/100ps
`default_nettype none

module rs_station #(
    parameter int ROB_ID_W = rs_pkg::ROB_ID_W
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              flush,
    input  logic                              load,
    input  rs_pkg::rs_entry_t                 load_entry,
    input  logic          [2**ROB_ID_W-1:0]   rob_ready,
    input  rs_pkg::word_t [2**ROB_ID_W-1:0]   rob_data,
    input  logic                              ex_done,
    input  rs_pkg::rob_id_t                   ex_rob_id,
    input  rs_pkg::word_t                     ex_data,
    output rs_pkg::rs_entry_t                 entry
);

    logic              valid_q;
    logic              r1_q;
    logic              r2_q;
    rs_pkg::rs_entry_t payload_q;

    logic              wake1;
    logic              wake2;
    rs_pkg::word_t     wake1_data;
    rs_pkg::word_t     wake2_data;

    // rob bus is checked first, own unit result as fallback
    always_comb begin
        wake1 = valid_q && !r1_q &&
                (rob_ready[payload_q.rob_id1] || (ex_done && ex_rob_id == payload_q.rob_id1));
        wake2 = valid_q && !r2_q &&
                (rob_ready[payload_q.rob_id2] || (ex_done && ex_rob_id == payload_q.rob_id2));
        wake1_data = rob_ready[payload_q.rob_id1] ? rob_data[payload_q.rob_id1] : ex_data;
        wake2_data = rob_ready[payload_q.rob_id2] ? rob_data[payload_q.rob_id2] : ex_data;
    end

    // control bits: flush, load, completion, then wakeup
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
            r1_q    <= 1'b0;
            r2_q    <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
            r1_q    <= 1'b0;
            r2_q    <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
            r1_q    <= load_entry.r1;
            r2_q    <= load_entry.r2;
        end else if (ex_done) begin
            valid_q <= 1'b0;
            r1_q    <= 1'b0;
            r2_q    <= 1'b0;
        end else begin
            if (wake1) begin
                r1_q <= 1'b1;
            end
            if (wake2) begin
                r2_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            payload_q <= load_entry;
        end else begin
            if (wake1) begin
                payload_q.rs1_v <= wake1_data;
            end
            if (wake2) begin
                payload_q.rs2_v <= wake2_data;
            end
        end
    end

    always_comb begin
        entry       = payload_q;
        entry.valid = valid_q;
        entry.r1    = r1_q;
        entry.r2    = r2_q;
    end

endmodule

`default_nettype wire

//--- rtl/rs_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module rs_dispatch #(
    parameter int NUM_RS   = rs_pkg::NUM_RS,
    parameter int ROB_ID_W = rs_pkg::ROB_ID_W
) (
    input  rs_pkg::rs_entry_t [NUM_RS-1:0]            station_entry,
    input  logic              [rs_pkg::DISPATCH_W-1:0] inst_valid,
    input  rs_pkg::opcode_t   [rs_pkg::DISPATCH_W-1:0] opcode,
    input  logic [rs_pkg::DISPATCH_W-1:0][2:0]         funct3,
    input  logic [rs_pkg::DISPATCH_W-1:0][6:0]         funct7,
    input  rs_pkg::word_t     [rs_pkg::DISPATCH_W-1:0] pc,
    input  rs_pkg::word_t     [rs_pkg::DISPATCH_W-1:0] imm_i,
    input  rs_pkg::word_t     [rs_pkg::DISPATCH_W-1:0] imm_u,
    input  rs_pkg::word_t     [rs_pkg::DISPATCH_W-1:0] imm_j,
    input  logic              [rs_pkg::DISPATCH_W-1:0] src1_ready,
    input  logic              [rs_pkg::DISPATCH_W-1:0] src2_ready,
    input  rs_pkg::word_t     [rs_pkg::DISPATCH_W-1:0] src1_data,
    input  rs_pkg::word_t     [rs_pkg::DISPATCH_W-1:0] src2_data,
    input  rs_pkg::rob_id_t   [rs_pkg::DISPATCH_W-1:0] src1_rob,
    input  rs_pkg::rob_id_t   [rs_pkg::DISPATCH_W-1:0] src2_rob,
    input  rs_pkg::rob_id_t   [rs_pkg::DISPATCH_W-1:0] rob_dest,
    input  logic              [2**ROB_ID_W-1:0]        rob_ready,
    input  rs_pkg::word_t     [2**ROB_ID_W-1:0]        rob_data,
    output logic              [NUM_RS-1:0]             load,
    output rs_pkg::rs_entry_t [NUM_RS-1:0]             load_entry
);

    localparam int IDX_W = $clog2(NUM_RS);

    // lane 0 takes the lowest free slot, lane 1 the highest
    logic [rs_pkg::DISPATCH_W-1:0][IDX_W-1:0] slot_idx;
    logic [rs_pkg::DISPATCH_W-1:0]            slot_found;
    rs_pkg::rs_entry_t [rs_pkg::DISPATCH_W-1:0] lane_entry;

    always_comb begin
        slot_idx   = '0;
        slot_found = '0;
        for (int i = 0; i < NUM_RS; i++) begin
            if (!station_entry[i].valid) begin
                if (!slot_found[0]) begin
                    slot_idx[0]   = IDX_W'(i);
                    slot_found[0] = 1'b1;
                end
                // last free index seen wins
                slot_idx[1]   = IDX_W'(i);
                slot_found[1] = 1'b1;
            end
        end
    end

    always_comb begin
        for (int l = 0; l < rs_pkg::DISPATCH_W; l++) begin
            lane_entry[l]          = '0;
            lane_entry[l].valid    = 1'b1;
            lane_entry[l].opcode   = opcode[l];
            lane_entry[l].funct3   = funct3[l];
            lane_entry[l].funct7   = funct7[l];
            lane_entry[l].rob_id1  = src1_rob[l];
            lane_entry[l].rob_id2  = src2_rob[l];
            lane_entry[l].rob_dest = rob_dest[l];
            lane_entry[l].alu_op   = rs_pkg::ALU_ADD;
            lane_entry[l].cmp_op   = rs_pkg::CMP_BEQ;
            lane_entry[l].use_cmp  = 1'b0;

            // register file first, then the rob bus for the same tag
            lane_entry[l].rs1_v = src1_ready[l] ? src1_data[l] : rob_data[src1_rob[l]];
            lane_entry[l].r1    = src1_ready[l] | rob_ready[src1_rob[l]];
            lane_entry[l].rs2_v = src2_ready[l] ? src2_data[l] : rob_data[src2_rob[l]];
            lane_entry[l].r2    = src2_ready[l] | rob_ready[src2_rob[l]];

            case (opcode[l])
                rs_pkg::OP_LUI: begin
                    lane_entry[l].rs1_v = imm_u[l];
                    lane_entry[l].rs2_v = '0;
                    lane_entry[l].r1    = 1'b1;
                    lane_entry[l].r2    = 1'b1;
                end
                rs_pkg::OP_AUIPC: begin
                    lane_entry[l].rs1_v = pc[l];
                    lane_entry[l].rs2_v = imm_u[l];
                    lane_entry[l].r1    = 1'b1;
                    lane_entry[l].r2    = 1'b1;
                end
                rs_pkg::OP_JAL: begin
                    lane_entry[l].rs1_v = pc[l];
                    lane_entry[l].rs2_v = imm_j[l];
                    lane_entry[l].r1    = 1'b1;
                    lane_entry[l].r2    = 1'b1;
                end
                rs_pkg::OP_JALR: begin
                    lane_entry[l].rs2_v = imm_i[l];
                    lane_entry[l].r2    = 1'b1;
                end
                rs_pkg::OP_IMM, rs_pkg::OP_REG: begin
                    if (opcode[l] == rs_pkg::OP_IMM) begin
                        lane_entry[l].rs2_v = imm_i[l];
                        lane_entry[l].r2    = 1'b1;
                    end
                    case (funct3[l])
                        rs_pkg::F3_SLT: begin
                            lane_entry[l].use_cmp = 1'b1;
                            lane_entry[l].cmp_op  = rs_pkg::CMP_BLT;
                        end
                        rs_pkg::F3_SLTU: begin
                            lane_entry[l].use_cmp = 1'b1;
                            lane_entry[l].cmp_op  = rs_pkg::CMP_BLTU;
                        end
                        rs_pkg::F3_SR: begin
                            lane_entry[l].alu_op = funct7[l][5] ? rs_pkg::ALU_SRA
                                                                : rs_pkg::ALU_SRL;
                        end
                        rs_pkg::F3_ADD: begin
                            // sub only exists in the register form
                            if (opcode[l] == rs_pkg::OP_REG && funct7[l][5]) begin
                                lane_entry[l].alu_op = rs_pkg::ALU_SUB;
                            end
                        end
                        default: begin
                            lane_entry[l].alu_op = rs_pkg::alu_op_t'(funct3[l]);
                        end
                    endcase
                end
                rs_pkg::OP_BR: begin
                    lane_entry[l].use_cmp = 1'b1;
                    lane_entry[l].cmp_op  = rs_pkg::cmp_op_t'(funct3[l]);
                end
                default: begin
                end
            endcase
        end
    end

    // steer lanes to stations, lane 0 wins a shared slot
    always_comb begin
        for (int i = 0; i < NUM_RS; i++) begin
            load[i]       = 1'b0;
            load_entry[i] = lane_entry[0];
            for (int l = rs_pkg::DISPATCH_W - 1; l >= 0; l--) begin
                if (inst_valid[l] && slot_found[l] && slot_idx[l] == IDX_W'(i)) begin
                    load[i]       = 1'b1;
                    load_entry[i] = lane_entry[l];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/rs_pkg.sv
`default_nettype none

package rs_pkg;

    // datapath and tag widths
    localparam int XLEN       = 32;
    localparam int ROB_ID_W   = 3;
    localparam int NUM_RS     = 8;
    localparam int DISPATCH_W = 2;

    typedef logic [ROB_ID_W-1:0] rob_id_t;
    typedef logic [XLEN-1:0]     word_t;

    // RV32I major opcodes handled by the stations
    typedef enum logic [6:0] {
        OP_LUI   = 7'b0110111,
        OP_AUIPC = 7'b0010111,
        OP_IMM   = 7'b0010011,
        OP_REG   = 7'b0110011,
        OP_JAL   = 7'b1101111,
        OP_JALR  = 7'b1100111,
        OP_BR    = 7'b1100011
    } opcode_t;

    // funct3 values that need special decode
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_SR   = 3'b101;

    // alu codes track funct3, sub and sra sit on the slt/sltu slots
    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SLL = 3'b001,
        ALU_SRA = 3'b010,
        ALU_SUB = 3'b011,
        ALU_XOR = 3'b100,
        ALU_SRL = 3'b101,
        ALU_OR  = 3'b110,
        ALU_AND = 3'b111
    } alu_op_t;

    // compare codes are the branch funct3 values
    typedef enum logic [2:0] {
        CMP_BEQ  = 3'b000,
        CMP_BNE  = 3'b001,
        CMP_BLT  = 3'b100,
        CMP_BGE  = 3'b101,
        CMP_BLTU = 3'b110,
        CMP_BGEU = 3'b111
    } cmp_op_t;

    typedef struct packed {
        logic    valid;
        opcode_t opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        alu_op_t alu_op;
        cmp_op_t cmp_op;
        logic    use_cmp;
        word_t   rs1_v;
        word_t   rs2_v;
        logic    r1;
        logic    r2;
        rob_id_t rob_id1;
        rob_id_t rob_id2;
        rob_id_t rob_dest;
    } rs_entry_t;

endpackage

`default_nettype wire
